/* Bender.yml */
package:
  name: road_game

sources:
  - files:
      - common/field_pkg.sv
      - common/game_pkg.sv
      - common/lane_if.sv
      - verilog/lane_spawner.sv
      - verilog/obstacle_lane.sv
      - player/player_ctrl.sv
      - verilog/hit_judge.sv
      - verilog/road_game.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/road_game_tb.sv

/* common/field_pkg.sv */
package field_pkg;

	// Playfield coordinates, origin at the top left
	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;

	localparam int FIELD_W = 320;
	localparam int FIELD_H = 240;

	// Car sits on a fixed row and only moves sideways
	localparam int CAR_W = 15;
	localparam int CAR_H = 30;
	localparam coord_y_t CAR_Y = 8'd190;
	localparam coord_x_t CAR_X_INIT = 9'd150;
	localparam coord_x_t CAR_X_MAX = coord_x_t'(FIELD_W - CAR_W); // 305

	// Bullet box and launch point
	localparam int BULLET_W = 5;
	localparam int BULLET_H = 5;
	localparam coord_y_t BULLET_Y_INIT = 8'd199;
	localparam int BULLET_OFS = 5; // From car left edge

	// Obstacle rows
	localparam coord_y_t LANE_Y_INIT = 8'd1;
	localparam coord_y_t LANE_Y_WRAP = 8'd221;

	localparam int N_LANES = 3;

	// Obstacle sizes, indexed by lane
	localparam int LANE_W [N_LANES] = '{45, 25, 20};
	localparam int LANE_H [N_LANES] = '{20, 25, 35};

endpackage

/* common/game_pkg.sv */
package game_pkg;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PLAY,
		ST_OVER
	} game_state_t;

	// Wraps at 256
	typedef logic [7:0] score_t;

	// Fibonacci LFSR, taps 16 14 13 11
	localparam logic [15:0] LFSR_SEED = 16'hACE1;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

endpackage

/* common/lane_if.sv */
interface lane_if;

	field_pkg::coord_x_t obs_x;    // Obstacle top left
	field_pkg::coord_y_t obs_y;
	field_pkg::coord_x_t spawn_x;  // Column offered for the next respawn
	logic hit;                     // One cycle, bullet struck this lane

	modport lane (
		output obs_x,
		output obs_y,
		input  spawn_x,
		input  hit
	);

	modport spawn (
		output spawn_x
	);

	modport judge (
		input  obs_x,
		input  obs_y,
		output hit
	);

endinterface

/* list.f */
+incdir+verif
common/field_pkg.sv
common/game_pkg.sv
common/lane_if.sv
verilog/lane_spawner.sv
verilog/obstacle_lane.sv
player/player_ctrl.sv
verilog/hit_judge.sv
verilog/road_game.sv
verif/road_game_tb.sv

/* player/player_ctrl.sv */
module player_ctrl #(
	parameter int BULLET_STEP = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic clear,
	input  logic frame_tick,
	input  logic left,
	input  logic right,
	input  logic shoot,
	input  logic bullet_kill,
	output field_pkg::coord_x_t car_x,
	output field_pkg::coord_x_t bullet_x,
	output field_pkg::coord_y_t bullet_y,
	output logic bullet_active
);

	logic step;
	logic launch;

	assign step = frame_tick && run;
	assign launch = step && shoot && !bullet_active;

	// Steering, both buttons together cancel out
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			car_x <= field_pkg::CAR_X_INIT;
		else if (clear)
			car_x <= field_pkg::CAR_X_INIT;
		else if (step)
		begin
			if (right && !left && car_x != field_pkg::CAR_X_MAX)
				car_x <= car_x + 9'd1;
			else if (left && !right && car_x != '0)
				car_x <= car_x - 9'd1;
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			bullet_active <= 1'b0;
		else if (clear || bullet_kill)
			bullet_active <= 1'b0;
		else if (launch)
			bullet_active <= 1'b1;
		else if (step && bullet_active && bullet_y < 8'(BULLET_STEP))
			bullet_active <= 1'b0; // Left the top of the screen
	end

	// Position only means something while bullet_active is high
	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			bullet_x <= car_x + 9'(field_pkg::BULLET_OFS); // Car column before this move
			bullet_y <= field_pkg::BULLET_Y_INIT;
		end
		else if (step && bullet_active)
			bullet_y <= bullet_y - 8'(BULLET_STEP);
	end

	a_bullet_on_field: assert property (
		@(posedge clk) disable iff (!rst)
		bullet_active |->
			(int'(bullet_x) + field_pkg::BULLET_W <= field_pkg::FIELD_W) &&
			(int'(bullet_y) + field_pkg::BULLET_H <= field_pkg::FIELD_H)
	);

endmodule

/* verif/road_game_checks.svh */
`ifndef ROAD_GAME_CHECKS_SVH
`define ROAD_GAME_CHECKS_SVH

task automatic check_state(input string name, input game_pkg::game_state_t got,
	input game_pkg::game_state_t exp);
	if (got !== exp)
	begin
		$display("Error: %s got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_x(input string name, input field_pkg::coord_x_t got,
	input field_pkg::coord_x_t exp);
	if (got !== exp)
	begin
		$display("Error: %s got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_y(input string name, input field_pkg::coord_y_t got,
	input field_pkg::coord_y_t exp);
	if (got !== exp)
	begin
		$display("Error: %s got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_score(input string name, input game_pkg::score_t got,
	input game_pkg::score_t exp);
	if (got !== exp)
	begin
		$display("Error: %s got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("Error: %s got %h expected %h", name, got, exp);
		abort_run();
	end
endtask

// Taps 16 14 13 11 are bits 15 13 12 10
function automatic logic [15:0] lfsr_next(input logic [15:0] v);
	return {v[14:0], v[15] ^ v[13] ^ v[12] ^ v[10]};
endfunction

function automatic field_pkg::coord_x_t spawn_col(input logic [15:0] v, input int lane);
	logic [15:0] r;
	int raw;
	int lim;
	r = v;
	for (int k = 0; k < 5 * lane; k++)
		r = {r[0], r[15:1]}; // Rotate right one bit
	raw = r[8:0];
	lim = field_pkg::FIELD_W - field_pkg::LANE_W[lane];
	if (raw >= lim)
		raw = raw - lim;
	return field_pkg::coord_x_t'(raw);
endfunction

// Half-open intervals, same as inclusive pixel spans
function automatic logic boxes_touch(input int ax, input int ay, input int aw, input int ah,
	input int bx, input int by, input int bw, input int bh);
	return ax < bx + bw && bx < ax + aw && ay < by + bh && by < ay + ah;
endfunction

`endif

/* verif/road_game_tb.sv */
module road_game_tb;

	localparam int NL = field_pkg::N_LANES;

	logic clk;
	logic rst;
	logic frame_tick;
	logic start;
	logic left;
	logic right;
	logic shoot;
	game_pkg::score_t score;
	game_pkg::game_state_t state;
	field_pkg::coord_x_t car_x;
	field_pkg::coord_x_t bullet_x;
	field_pkg::coord_y_t bullet_y;
	logic bullet_active;
	field_pkg::coord_x_t obs_x [NL];
	field_pkg::coord_y_t obs_y [NL];

	// Reference model
	logic [15:0] m_lfsr;
	field_pkg::coord_x_t m_car;
	field_pkg::coord_x_t m_bx;
	field_pkg::coord_y_t m_by;
	logic m_bact;
	field_pkg::coord_x_t m_ox [NL];
	field_pkg::coord_y_t m_oy [NL];
	game_pkg::score_t m_score;
	game_pkg::game_state_t m_state;
	int m_hits;
	int m_wraps [NL];

	road_game DUT (
		.clk           (clk),
		.rst           (rst),
		.frame_tick    (frame_tick),
		.start         (start),
		.left          (left),
		.right         (right),
		.shoot         (shoot),
		.score         (score),
		.state         (state),
		.car_x         (car_x),
		.bullet_x      (bullet_x),
		.bullet_y      (bullet_y),
		.bullet_active (bullet_active),
		.obs_x         (obs_x),
		.obs_y         (obs_y)
	);

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	`include "road_game_checks.svh"

	task automatic model_start();
		m_car = field_pkg::CAR_X_INIT;
		m_bact = 1'b0;
		m_score = '0;
		m_state = game_pkg::ST_PLAY;
		for (int i = 0; i < NL; i++)
		begin
			m_ox[i] = '0;
			m_oy[i] = field_pkg::LANE_Y_INIT;
		end
	endtask

	task automatic model_tick(input logic l, input logic r, input logic s);
		field_pkg::coord_x_t sp [NL];
		logic crash;
		if (m_state == game_pkg::ST_PLAY)
		begin
			for (int i = 0; i < NL; i++)
			begin
				sp[i] = spawn_col(m_lfsr, i);
				if (int'(m_oy[i]) + 1 >= int'(field_pkg::LANE_Y_WRAP))
				begin
					m_oy[i] = field_pkg::LANE_Y_INIT;
					m_ox[i] = sp[i];
					m_wraps[i]++;
				end
				else
					m_oy[i] = m_oy[i] + 1;
			end
			if (s && !m_bact)
			begin
				m_bact = 1'b1;
				m_bx = m_car + 5; // Launch from the old car column
				m_by = field_pkg::BULLET_Y_INIT;
			end
			else if (m_bact)
			begin
				if (m_by < 4)
					m_bact = 1'b0;
				else
					m_by = m_by - 4;
			end
			if (r && !l && m_car != 305)
				m_car = m_car + 1;
			else if (l && !r && m_car != 0)
				m_car = m_car - 1;
		end
		m_lfsr = lfsr_next(m_lfsr);
		if (m_state == game_pkg::ST_PLAY)
		begin
			crash = 1'b0;
			for (int i = 0; i < NL; i++)
				crash |= boxes_touch(m_car, 190, 15, 30, m_ox[i], m_oy[i],
					field_pkg::LANE_W[i], field_pkg::LANE_H[i]);
			if (crash)
				m_state = game_pkg::ST_OVER;
			else
				for (int i = 0; i < NL; i++)
					if (m_bact && boxes_touch(m_bx, m_by, 5, 5, m_ox[i], m_oy[i],
						field_pkg::LANE_W[i], field_pkg::LANE_H[i]))
					begin
						m_hits++;
						m_score = m_score + 1;
						m_ox[i] = spawn_col(m_lfsr, i); // Generator already stepped
						m_oy[i] = field_pkg::LANE_Y_INIT;
						m_bact = 1'b0;
						break;
					end
		end
	endtask

	task automatic check_all();
		check_state("state", state, m_state);
		check_score("score", score, m_score);
		check_x("car_x", car_x, m_car);
		check_bit("bullet_active", bullet_active, m_bact);
		if (m_bact)
		begin
			check_x("bullet_x", bullet_x, m_bx);
			check_y("bullet_y", bullet_y, m_by);
		end
		for (int i = 0; i < NL; i++)
		begin
			check_x($sformatf("obs_x[%0d]", i), obs_x[i], m_ox[i]);
			check_y($sformatf("obs_y[%0d]", i), obs_y[i], m_oy[i]);
		end
	endtask

	task automatic tick_frame(input logic l, input logic r, input logic s);
		@(posedge clk);
		left <= l;
		right <= r;
		shoot <= s;
		frame_tick <= 1'b1;
		@(posedge clk);
		frame_tick <= 1'b0;
		for (int n = 0; n < 4; n++)
			@(posedge clk);
		@(negedge clk); // Sample away from the drive edge
		model_tick(l, r, s);
		check_all();
	endtask

	task automatic start_game();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		model_start();
		check_all();
	endtask

	task automatic ensure_play();
		if (m_state != game_pkg::ST_PLAY)
			start_game();
	endtask

	task automatic test_reset_idle();
		check_state("state", state, game_pkg::ST_IDLE);
		check_score("score", score, 8'd0);
		check_x("car_x", car_x, 9'd150);
		for (int n = 0; n < 5; n++)
			tick_frame(1'b1, 1'b0, 1'b0);
		check_x("car_x", car_x, 9'd150);
	endtask

	task automatic test_steering();
		field_pkg::coord_x_t held;
		int guard;
		start_game();
		for (int n = 0; n < 160; n++)
			tick_frame(1'b0, 1'b1, 1'b0);
		check_x("car_x", car_x, 9'd305);
		guard = 0;
		while (m_car != 0)
		begin
			ensure_play(); // Obstacles may end the walk early
			tick_frame(1'b1, 1'b0, 1'b0);
			guard++;
			if (guard > 2000)
			begin
				$display("Car never walked back to column 0");
				abort_run();
			end
		end
		ensure_play();
		tick_frame(1'b0, 1'b1, 1'b0); // Off the edge, so either button alone would move it
		held = m_car;
		tick_frame(1'b1, 1'b1, 1'b0);
		tick_frame(1'b1, 1'b1, 1'b0);
		check_x("car_x", car_x, held);
	endtask

	task automatic test_falling();
		int guard;
		for (int i = 0; i < NL; i++)
			m_wraps[i] = 0;
		guard = 0;
		while (m_wraps[0] == 0 || m_wraps[1] == 0 || m_wraps[2] == 0)
		begin
			ensure_play();
			tick_frame(1'b0, 1'b1, 1'b0); // Park at the right edge
			guard++;
			if (guard > 3000)
			begin
				$display("Not every lane wrapped in time");
				abort_run();
			end
		end
	endtask

	task automatic test_shooting();
		int guard;
		int hits0;
		hits0 = m_hits;
		guard = 0;
		while (m_hits == hits0)
		begin
			ensure_play();
			tick_frame(1'b0, 1'b0, 1'b1);
			guard++;
			if (guard > 5000)
			begin
				$display("Bullet never hit an obstacle");
				abort_run();
			end
		end
	endtask

	task automatic test_crash_restart();
		int guard;
		ensure_play();
		guard = 0;
		while (m_state != game_pkg::ST_OVER)
		begin
			tick_frame(1'b0, 1'b0, 1'b0);
			guard++;
			if (guard > 5000)
			begin
				$display("No obstacle ever reached the car");
				abort_run();
			end
		end
		for (int n = 0; n < 3; n++)
			tick_frame(1'b1, 1'b0, 1'b1); // Everything stays frozen
		start_game();
		check_state("state", state, game_pkg::ST_PLAY);
		check_score("score", score, 8'd0);
		check_x("car_x", car_x, 9'd150);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		rst = 1'b0;
		frame_tick = 1'b0;
		start = 1'b0;
		left = 1'b0;
		right = 1'b0;
		shoot = 1'b0;
		m_lfsr = game_pkg::LFSR_SEED;
		m_hits = 0;
		model_start();
		m_state = game_pkg::ST_IDLE;
		for (int n = 0; n < 5; n++)
			@(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		test_reset_idle();
		test_steering();
		test_falling();
		test_shooting();
		test_crash_restart();
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* verilog/hit_judge.sv */
module hit_judge (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  field_pkg::coord_x_t car_x,
	input  field_pkg::coord_x_t bullet_x,
	input  field_pkg::coord_y_t bullet_y,
	input  logic bullet_active,
	input  logic frame_tick,
	lane_if.judge lanes [field_pkg::N_LANES],
	output logic run,
	output logic clear,
	output logic bullet_kill,
	output game_pkg::score_t score,
	output game_pkg::game_state_t state
);

	localparam int N = field_pkg::N_LANES;

	logic tick_d;            // High in the cycle after a frame tick
	logic crash;
	logic [N-1:0] car_hit;
	logic [N-1:0] bul_hit;
	logic [N-1:0] pick;
	logic [N-1:0] hit_q;

	// Boxes cover [x, x+w-1] by [y, y+h-1], a shared pixel counts
	function automatic logic overlap(
		input int ax,
		input int ay,
		input int aw,
		input int ah,
		input int bx,
		input int by,
		input int bw,
		input int bh
	);
		return (ax <= bx + bw - 1) && (bx <= ax + aw - 1) &&
			(ay <= by + bh - 1) && (by <= ay + ah - 1);
	endfunction

	for (genvar i = 0; i < N; i++)
	begin : g_lane
		assign car_hit[i] = overlap(car_x, field_pkg::CAR_Y,
			field_pkg::CAR_W, field_pkg::CAR_H,
			lanes[i].obs_x, lanes[i].obs_y,
			field_pkg::LANE_W[i], field_pkg::LANE_H[i]);
		assign bul_hit[i] = bullet_active && overlap(bullet_x, bullet_y,
			field_pkg::BULLET_W, field_pkg::BULLET_H,
			lanes[i].obs_x, lanes[i].obs_y,
			field_pkg::LANE_W[i], field_pkg::LANE_H[i]);
		assign lanes[i].hit = hit_q[i];
	end

	assign crash = |car_hit;
	assign pick = bul_hit & ~(bul_hit - 1'b1); // Lowest lane wins

	assign run = state == game_pkg::ST_PLAY;
	assign clear = start && state != game_pkg::ST_PLAY;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= game_pkg::ST_IDLE;
			score <= '0;
			hit_q <= '0;
			bullet_kill <= 1'b0;
			tick_d <= 1'b0;
		end
		else
		begin
			tick_d <= frame_tick;
			hit_q <= '0;         // Strobes
			bullet_kill <= 1'b0;
			case (state)
				game_pkg::ST_IDLE, game_pkg::ST_OVER:
				begin
					if (start)
					begin
						state <= game_pkg::ST_PLAY;
						score <= '0;
					end
				end
				game_pkg::ST_PLAY:
				begin
					if (tick_d && crash)
						state <= game_pkg::ST_OVER; // Crash beats any bullet hit
					else if (tick_d && |bul_hit)
					begin
						hit_q <= pick;
						bullet_kill <= 1'b1;
						score <= score + 8'd1;
					end
				end
				default: state <= game_pkg::ST_IDLE;
			endcase
		end
	end

	a_one_hit: assert property (
		@(posedge clk) disable iff (!rst)
		$onehot0(hit_q)
	);

endmodule

/* verilog/lane_spawner.sv */
module lane_spawner (
	input  logic clk,
	input  logic rst,
	input  logic frame_tick,
	lane_if.spawn lanes [field_pkg::N_LANES]
);

	logic [15:0] lfsr;
	logic [31:0] lfsr_dbl;

	// Doubled copy so a right shift acts as a rotate
	assign lfsr_dbl = {lfsr, lfsr};

	// Steps once per frame, even outside a game
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			lfsr <= game_pkg::LFSR_SEED;
		else if (frame_tick)
			lfsr <= {lfsr[14:0], ^(lfsr & game_pkg::LFSR_TAPS)};
	end

	for (genvar i = 0; i < field_pkg::N_LANES; i++)
	begin : g_col
		// Leftmost column that still keeps the whole obstacle on screen
		localparam logic [8:0] LIMIT = 9'(field_pkg::FIELD_W - field_pkg::LANE_W[i]);

		logic [15:0] rot;
		logic [8:0] raw;

		assign rot = 16'(lfsr_dbl >> (5 * i)); // Each lane sees a different slice
		assign raw = rot[8:0];

		// One subtraction is enough, raw never reaches twice the limit
		assign lanes[i].spawn_x = (raw >= LIMIT) ? raw - LIMIT : raw;

		a_spawn_on_field: assert property (
			@(posedge clk) disable iff (!rst)
			lanes[i].spawn_x < field_pkg::FIELD_W
		);
	end

endmodule

/* verilog/obstacle_lane.sv */
module obstacle_lane #(
	parameter int LANE = 0,
	parameter int FALL_STEP = 1
) (
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic clear,
	input  logic frame_tick,
	lane_if.lane lane
);

	field_pkg::coord_x_t x_q;
	field_pkg::coord_y_t y_q;
	logic [8:0] y_next; // Extra bit so the sum cannot wrap
	logic wrap;

	assign y_next = {1'b0, y_q} + 9'(FALL_STEP);
	assign wrap = y_next >= 9'(field_pkg::LANE_Y_WRAP);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			x_q <= '0;
			y_q <= field_pkg::LANE_Y_INIT;
		end
		else if (clear)
		begin
			x_q <= '0;
			y_q <= field_pkg::LANE_Y_INIT;
		end
		else if (lane.hit)
		begin
			// Shot down, back to the top at a fresh column
			x_q <= lane.spawn_x;
			y_q <= field_pkg::LANE_Y_INIT;
		end
		else if (frame_tick && run)
		begin
			if (wrap)
			begin
				x_q <= lane.spawn_x;
				y_q <= field_pkg::LANE_Y_INIT;
			end
			else
				y_q <= y_next[7:0];
		end
	end

	assign lane.obs_x = x_q;
	assign lane.obs_y = y_q;

	a_row_in_range: assert property (
		@(posedge clk) disable iff (!rst)
		y_q <= field_pkg::LANE_Y_WRAP
	);

	// Spawner must size its column to this lane's width
	a_box_on_field: assert property (
		@(posedge clk) disable iff (!rst)
		int'(x_q) + field_pkg::LANE_W[LANE] <= field_pkg::FIELD_W
	);

endmodule

/* verilog/road_game.sv */
module road_game #(
	parameter int FALL_STEP = 1,
	parameter int BULLET_STEP = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic frame_tick,
	input  logic start,
	input  logic left,
	input  logic right,
	input  logic shoot,
	output game_pkg::score_t score,
	output game_pkg::game_state_t state,
	output field_pkg::coord_x_t car_x,
	output field_pkg::coord_x_t bullet_x,
	output field_pkg::coord_y_t bullet_y,
	output logic bullet_active,
	output field_pkg::coord_x_t obs_x [field_pkg::N_LANES],
	output field_pkg::coord_y_t obs_y [field_pkg::N_LANES]
);

	logic run;
	logic clear;
	logic bullet_kill;

	lane_if lanes [field_pkg::N_LANES] ();

	lane_spawner u_spawner (
		.clk        (clk),
		.rst        (rst),
		.frame_tick (frame_tick),
		.lanes      (lanes)
	);

	// One falling obstacle per lane
	for (genvar i = 0; i < field_pkg::N_LANES; i++)
	begin : g_lane
		obstacle_lane #(
			.LANE      (i),
			.FALL_STEP (FALL_STEP)
		) u_lane (
			.clk        (clk),
			.rst        (rst),
			.run        (run),
			.clear      (clear),
			.frame_tick (frame_tick),
			.lane       (lanes[i])
		);

		assign obs_x[i] = lanes[i].obs_x;
		assign obs_y[i] = lanes[i].obs_y;
	end

	player_ctrl #(
		.BULLET_STEP (BULLET_STEP)
	) u_player (
		.clk           (clk),
		.rst           (rst),
		.run           (run),
		.clear         (clear),
		.frame_tick    (frame_tick),
		.left          (left),
		.right         (right),
		.shoot         (shoot),
		.bullet_kill   (bullet_kill),
		.car_x         (car_x),
		.bullet_x      (bullet_x),
		.bullet_y      (bullet_y),
		.bullet_active (bullet_active)
	);

	hit_judge u_judge (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.car_x         (car_x),
		.bullet_x      (bullet_x),
		.bullet_y      (bullet_y),
		.bullet_active (bullet_active),
		.frame_tick    (frame_tick),
		.lanes         (lanes),
		.run           (run),
		.clear         (clear),
		.bullet_kill   (bullet_kill),
		.score         (score),
		.state         (state)
	);

endmodule
